/* common/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Instruction memory word-address width
`define IMEM_AW 10

// Data memory word-address width
`define DMEM_AW 10

// Byte address of the IO word
`define IO_BASE 14'h3F00

// Word index fetched first after upload
`define RESET_PC 0

`endif

/* common/cpuPkg.sv */
`default_nettype none
`include "cpu_config.svh"

package cpuPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] regAddr_t;
    typedef logic [`IMEM_AW-1:0] imemAddr_t;   // Instruction word index
    typedef logic [3:0] aluOp_t;

    localparam aluOp_t ALU_ADD = 4'd0;
    localparam aluOp_t ALU_SUB = 4'd1;
    localparam aluOp_t ALU_AND = 4'd2;
    localparam aluOp_t ALU_OR  = 4'd3;
    localparam aluOp_t ALU_XOR = 4'd4;
    localparam aluOp_t ALU_SLL = 4'd5;
    localparam aluOp_t ALU_SRL = 4'd6;
    localparam aluOp_t ALU_SLT = 4'd7;

    // Where an execute operand comes from
    typedef enum logic [1:0] {
        FWD_RF  = 2'd0,   // Value read in decode
        FWD_MEM = 2'd1,   // ALU result in the memory stage
        FWD_WB  = 2'd2    // Writeback value
    } fwdSel_e;

    typedef enum logic [1:0] {
        RS_LOADING  = 2'd0,
        RS_STARTING = 2'd1,
        RS_RUNNING  = 2'd2
    } runState_e;

    // RV32I major opcodes
    localparam logic [6:0] OP_RTYPE  = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    localparam word_t NOP_INSTR = 32'h0000_0013;   // addi x0, x0, 0

endpackage

`default_nettype wire

/* src/fetch/instrFetch.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_config.svh"

module instrFetch import cpuPkg::*; (
    input  wire logic      clk,
    input  wire logic      rstN_i,
    input  wire logic      upgWen_i,
    input  wire imemAddr_t upgAddr_i,
    input  wire word_t     upgData_i,
    input  wire logic      pcHold_i,      // Core held during upload
    input  wire logic      pcLoad_i,      // Taken branch or JAL
    input  wire imemAddr_t jumpTarget_i,
    input  wire logic      flushId_i,
    output word_t          idInstr_o,
    output imemAddr_t      idPc_o
);
    imemAddr_t pc;
    word_t imem [2**`IMEM_AW];
    word_t fetched;

    assign fetched = imem[pc];   // Asynchronous read

    // Program upload, only while the core is held
    always_ff @(posedge clk) begin
        if (upgWen_i && pcHold_i) begin
            imem[upgAddr_i] <= upgData_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN_i || pcHold_i) begin
            pc <= imemAddr_t'(`RESET_PC);
        end else if (pcLoad_i) begin
            pc <= jumpTarget_i;
        end else begin
            pc <= pc + 1'b1;   // Next word
        end
    end

    // Fetch/decode register, a flush leaves a no-op behind
    always_ff @(posedge clk) begin
        if (!rstN_i || flushId_i) begin
            idInstr_o <= NOP_INSTR;
            idPc_o <= '0;
        end else begin
            idInstr_o <= fetched;
            idPc_o <= pc;
        end
    end

    // Branches resolve only once the pipeline runs
    pcLoadWhileHeld: assert property (@(posedge clk) disable iff (!rstN_i)
        pcHold_i |-> !pcLoad_i)
        else $error("PC load requested while the core is held");

endmodule

`default_nettype wire

/* src/decode/instrDecode.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_config.svh"

module instrDecode import cpuPkg::*; (
    input  wire logic      clk,
    input  wire logic      rstN_i,
    input  wire word_t     idInstr_i,
    input  wire imemAddr_t idPc_i,
    input  wire logic      flushEx_i,
    input  wire logic      regWrite_i, memRead_i, memWrite_i, aluSrc_i,
    input  wire aluOp_t    aluOp_i,
    input  wire logic      wbRegWrite_i,
    input  wire regAddr_t  wbRd_i,
    input  wire word_t     wbData_i,
    output logic           branchTaken_o,
    output imemAddr_t      jumpTarget_o,
    output regAddr_t       exRs1_o, exRs2_o, exRd_o,
    output word_t          exA_o, exB_o, exImm_o,
    output aluOp_t         exAluOp_o,
    output logic           exAluSrc_o, exRegWrite_o, exMemRead_o, exMemWrite_o
);
    word_t regFile [32];
    logic [6:0] opcode;
    logic [2:0] funct3;
    regAddr_t rs1, rs2, rd;
    word_t rdA, rdB;
    word_t immI, immS, immB, immJ;
    word_t pcByte, target;
    logic isBeq, isJal, isStore;

    assign opcode = idInstr_i[6:0];
    assign rd = idInstr_i[11:7];
    assign funct3 = idInstr_i[14:12];
    assign rs1 = idInstr_i[19:15];
    assign rs2 = idInstr_i[24:20];

    assign isBeq = (opcode == OP_BRANCH) && (funct3 == 3'b000);
    assign isJal = opcode == OP_JAL;
    assign isStore = opcode == OP_STORE;

    assign immI = {{20{idInstr_i[31]}}, idInstr_i[31:20]};
    assign immS = {{20{idInstr_i[31]}}, idInstr_i[31:25], idInstr_i[11:7]};
    assign immB = {{19{idInstr_i[31]}}, idInstr_i[31], idInstr_i[7],
                   idInstr_i[30:25], idInstr_i[11:8], 1'b0};
    assign immJ = {{11{idInstr_i[31]}}, idInstr_i[31], idInstr_i[19:12],
                   idInstr_i[20], idInstr_i[30:21], 1'b0};

    always_ff @(posedge clk) begin
        if (wbRegWrite_i) begin
            regFile[wbRd_i] <= wbData_i;
        end
    end

    // x0 reads zero, a value in writeback is passed straight through
    assign rdA = (rs1 == '0) ? '0 :
                 (wbRegWrite_i && wbRd_i == rs1) ? wbData_i : regFile[rs1];
    assign rdB = (rs2 == '0) ? '0 :
                 (wbRegWrite_i && wbRd_i == rs2) ? wbData_i : regFile[rs2];

    // Branch and jump resolved here
    assign pcByte = word_t'({idPc_i, 2'b00});
    assign target = pcByte + (isJal ? immJ : immB);
    assign branchTaken_o = isJal || (isBeq && rdA == rdB);
    assign jumpTarget_o = target[`IMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (!rstN_i || flushEx_i) begin
            exRs1_o <= '0;
            exRs2_o <= '0;
            exRd_o <= '0;
            exAluOp_o <= ALU_ADD;
            exAluSrc_o <= 1'b0;
            exRegWrite_o <= 1'b0;
            exMemRead_o <= 1'b0;
            exMemWrite_o <= 1'b0;
        end else begin
            exRs1_o <= isJal ? '0 : rs1;   // Keeps forwarding off the link operand
            exRs2_o <= rs2;
            exRd_o <= rd;
            exAluOp_o <= aluOp_i;
            exAluSrc_o <= aluSrc_i;
            exRegWrite_o <= regWrite_i;
            exMemRead_o <= memRead_i;
            exMemWrite_o <= memWrite_i;
        end
    end

    // Operand values
    always_ff @(posedge clk) begin
        exA_o <= isJal ? pcByte : rdA;   // JAL link is PC + 4
        exB_o <= rdB;
        exImm_o <= isJal ? 32'd4 : (isStore ? immS : immI);
    end

    // Control must never let a write to x0 reach writeback
    noWriteX0: assert property (@(posedge clk) disable iff (!rstN_i)
        wbRegWrite_i |-> wbRd_i != '0)
        else $error("Writeback to register 0");

endmodule

`default_nettype wire

/* src/decode/pipeControl.sv */
`timescale 1ns/1ns
`default_nettype none

module pipeControl import cpuPkg::*; (
    input  wire logic     clk,
    input  wire logic     rstN_i,
    input  wire logic     upgDone_i,
    input  wire word_t    idInstr_i,
    input  wire logic     branchTaken_i,
    input  wire regAddr_t exRs1_i,
    input  wire regAddr_t exRs2_i,
    input  wire regAddr_t memRd_i,
    input  wire logic     memRegWrite_i,
    input  wire regAddr_t wbRd_i,
    input  wire logic     wbRegWrite_i,
    output logic          regWrite_o, memRead_o, memWrite_o, aluSrc_o,
    output aluOp_t        aluOp_o,
    output fwdSel_e       fwdA_o, fwdB_o,
    output logic          pcHold_o,
    output logic          pcLoad_o,
    output logic          flushId_o,
    output logic          flushEx_o
);
    runState_e runState, runStateNext;
    logic running;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic funct7b5;
    regAddr_t rd;

    assign opcode = idInstr_i[6:0];
    assign rd = idInstr_i[11:7];
    assign funct3 = idInstr_i[14:12];
    assign funct7b5 = idInstr_i[30];

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            runState <= RS_LOADING;
        end else begin
            runState <= runStateNext;
        end
    end

    always_comb begin
        runStateNext = runState;
        case (runState)
            RS_LOADING: if (upgDone_i) runStateNext = RS_STARTING;
            RS_STARTING: runStateNext = upgDone_i ? RS_RUNNING : RS_LOADING;
            RS_RUNNING: if (!upgDone_i) runStateNext = RS_LOADING;
            default: runStateNext = RS_LOADING;
        endcase
    end

    // Pipeline stays flushed and the PC parked until running
    assign running = runState == RS_RUNNING;
    assign pcHold_o = !running;
    assign flushEx_o = !running;
    assign flushId_o = !running || branchTaken_i;   // One slot lost per taken branch
    assign pcLoad_o = running && branchTaken_i;

    always_comb begin
        regWrite_o = 1'b0;
        memRead_o = 1'b0;
        memWrite_o = 1'b0;
        aluSrc_o = 1'b0;
        aluOp_o = ALU_ADD;
        case (opcode)
            OP_RTYPE: begin
                regWrite_o = 1'b1;
                case (funct3)
                    3'b000: aluOp_o = funct7b5 ? ALU_SUB : ALU_ADD;
                    3'b001: aluOp_o = ALU_SLL;
                    3'b010: aluOp_o = ALU_SLT;
                    3'b100: aluOp_o = ALU_XOR;
                    3'b101: begin
                        aluOp_o = ALU_SRL;
                        regWrite_o = !funct7b5;   // SRA is not supported
                    end
                    3'b110: aluOp_o = ALU_OR;
                    3'b111: aluOp_o = ALU_AND;
                    default: regWrite_o = 1'b0;
                endcase
            end
            OP_IMM: begin
                aluSrc_o = 1'b1;
                regWrite_o = funct3 == 3'b000;   // ADDI only
            end
            OP_LOAD: begin
                aluSrc_o = 1'b1;
                memRead_o = funct3 == 3'b010;   // Word loads only
                regWrite_o = funct3 == 3'b010;
            end
            OP_STORE: begin
                aluSrc_o = 1'b1;
                memWrite_o = funct3 == 3'b010;
            end
            OP_JAL: begin
                aluSrc_o = 1'b1;
                regWrite_o = 1'b1;
            end
            default: regWrite_o = 1'b0;   // BEQ and unknown opcodes
        endcase
        if (rd == '0) begin
            regWrite_o = 1'b0;
        end
    end

    // Newer memory-stage value wins over writeback
    // Decode never enables a write to x0 so x0 cannot match
    function automatic fwdSel_e pickSource(input regAddr_t rs);
        if (memRegWrite_i && memRd_i == rs) begin
            return FWD_MEM;
        end else if (wbRegWrite_i && wbRd_i == rs) begin
            return FWD_WB;
        end
        return FWD_RF;
    endfunction

    always_comb begin
        fwdA_o = pickSource(exRs1_i);
        fwdB_o = pickSource(exRs2_i);
    end

    fwdFromX0: assert property (@(posedge clk) disable iff (!rstN_i)
        fwdA_o != FWD_RF |-> ((fwdA_o == FWD_MEM) ? memRd_i : wbRd_i) != '0)
        else $error("Operand A forwarded from a stage writing register 0");

endmodule

`default_nettype wire

/* src/execute/aluUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module aluUnit import cpuPkg::*; (
    input  wire logic     clk,
    input  wire logic     rstN_i,
    input  wire fwdSel_e  fwdA_i, fwdB_i,
    input  wire word_t    exA_i, exB_i, exImm_i,
    input  wire aluOp_t   exAluOp_i,
    input  wire logic     exAluSrc_i,
    input  wire regAddr_t exRd_i,
    input  wire logic     exRegWrite_i, exMemRead_i, exMemWrite_i,
    input  wire word_t    wbData_i,
    output word_t         memAddr_o,        // ALU result, also the forwarded value
    output word_t         memStoreData_o,
    output regAddr_t      memRd_o,
    output logic          memRegWrite_o, memRead_o, memWrite_o
);
    word_t opA, opB, aluB, result;

    function automatic word_t fwdMux(input fwdSel_e sel, input word_t regVal,
                                     input word_t memVal, input word_t wbVal);
        case (sel)
            FWD_MEM: return memVal;
            FWD_WB: return wbVal;
            default: return regVal;
        endcase
    endfunction

    always_comb begin
        opA = fwdMux(fwdA_i, exA_i, memAddr_o, wbData_i);
        opB = fwdMux(fwdB_i, exB_i, memAddr_o, wbData_i);
    end

    assign aluB = exAluSrc_i ? exImm_i : opB;

    always_comb begin
        case (exAluOp_i)
            ALU_SUB: result = opA - aluB;
            ALU_AND: result = opA & aluB;
            ALU_OR: result = opA | aluB;
            ALU_XOR: result = opA ^ aluB;
            ALU_SLL: result = opA << aluB[4:0];
            ALU_SRL: result = opA >> aluB[4:0];
            ALU_SLT: result = {31'b0, $signed(opA) < $signed(aluB)};
            default: result = opA + aluB;   // ADD, address and link
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            memRd_o <= '0;
            memRegWrite_o <= 1'b0;
            memRead_o <= 1'b0;
            memWrite_o <= 1'b0;
        end else begin
            memRd_o <= exRd_i;
            memRegWrite_o <= exRegWrite_i;
            memRead_o <= exMemRead_i;
            memWrite_o <= exMemWrite_i;
        end
    end

    always_ff @(posedge clk) begin
        memAddr_o <= result;
        memStoreData_o <= opB;   // Store data after forwarding
    end

endmodule

`default_nettype wire

/* src/memory/memOrIo.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_config.svh"

module memOrIo import cpuPkg::*; (
    input  wire logic     clk,
    input  wire logic     rstN_i,
    input  wire word_t    memAddr_i,
    input  wire word_t    memStoreData_i,
    input  wire regAddr_t memRd_i,
    input  wire logic     memRegWrite_i,
    input  wire logic     memRead_i,
    input  wire logic     memWrite_i,
    input  wire logic [15:0] ioIn_i,
    output word_t         wbData_o,
    output regAddr_t      wbRd_o,
    output logic          wbRegWrite_o,
    output word_t         ioOut_o,
    output logic          ioWe_o
);
    localparam logic [13:0] IoBase = `IO_BASE;
    localparam int DmemWords = 2 ** `DMEM_AW;

    word_t dmem [DmemWords];
    logic ioSel;
    logic [`DMEM_AW-1:0] dmemIdx;
    word_t loadData;

    // Low 14 address bits, so offset -256 from x0 also lands on the IO word
    assign ioSel = memAddr_i[13:2] == IoBase[13:2];
    assign dmemIdx = memAddr_i[`DMEM_AW+1:2];
    assign loadData = ioSel ? {16'b0, ioIn_i} : dmem[dmemIdx];

    // Data memory is cleared by reset
    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            for (int i = 0; i < DmemWords; i++) begin
                dmem[i] <= '0;
            end
        end else if (memWrite_i && !ioSel) begin
            dmem[dmemIdx] <= memStoreData_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            ioOut_o <= '0;
            ioWe_o <= 1'b0;
        end else begin
            ioWe_o <= memWrite_i && ioSel;   // One-cycle strobe per IO store
            if (memWrite_i && ioSel) begin
                ioOut_o <= memStoreData_i;
            end
        end
    end

    // Memory/writeback register
    always_ff @(posedge clk) begin
        if (!rstN_i) begin
            wbRd_o <= '0;
            wbRegWrite_o <= 1'b0;
        end else begin
            wbRd_o <= memRd_i;
            wbRegWrite_o <= memRegWrite_i;
        end
    end

    always_ff @(posedge clk) begin
        wbData_o <= memRead_i ? loadData : memAddr_i;
    end

    // Control from decode never sets both
    loadAndStore: assert property (@(posedge clk) disable iff (!rstN_i)
        !(memRead_i && memWrite_i))
        else $error("Load and store in the same memory-stage slot");

endmodule

`default_nettype wire

/* src/cpuTop.sv */
`timescale 1ns/1ns
`default_nettype none

module cpuTop import cpuPkg::*; (
    input  wire logic      clk,
    input  wire logic      rstN_i,
    input  wire logic      upgWen_i,    // Upload write strobe
    input  wire imemAddr_t upgAddr_i,
    input  wire word_t     upgData_i,
    input  wire logic      upgDone_i,   // High once the program is in place
    input  wire logic [15:0] ioIn_i,
    output word_t          ioOut_o,
    output logic           ioWe_o
);
    // Fetch and control
    logic pcHold, pcLoad, flushId, flushEx;
    imemAddr_t jumpTarget;
    word_t idInstr;
    imemAddr_t idPc;
    logic branchTaken;

    // Decode-stage control from pipeControl
    logic ctlRegWrite, ctlMemRead, ctlMemWrite, ctlAluSrc;
    aluOp_t ctlAluOp;

    // Execute stage
    regAddr_t exRs1, exRs2, exRd;
    word_t exA, exB, exImm;
    aluOp_t exAluOp;
    logic exAluSrc, exRegWrite, exMemRead, exMemWrite;
    fwdSel_e fwdA, fwdB;

    // Memory stage
    word_t memAddr, memStoreData;
    regAddr_t memRd;
    logic memRegWrite, memRead, memWrite;

    // Writeback
    word_t wbData;
    regAddr_t wbRd;
    logic wbRegWrite;

    instrFetch ifetch(clk, rstN_i, upgWen_i, upgAddr_i, upgData_i,
        pcHold, pcLoad, jumpTarget, flushId,
        idInstr, idPc);

    instrDecode decoder(clk, rstN_i, idInstr, idPc, flushEx,
        ctlRegWrite, ctlMemRead, ctlMemWrite, ctlAluSrc, ctlAluOp,
        wbRegWrite, wbRd, wbData,
        branchTaken, jumpTarget,
        exRs1, exRs2, exRd, exA, exB, exImm,
        exAluOp, exAluSrc, exRegWrite, exMemRead, exMemWrite);

    pipeControl control(clk, rstN_i, upgDone_i, idInstr, branchTaken,
        exRs1, exRs2, memRd, memRegWrite, wbRd, wbRegWrite,
        ctlRegWrite, ctlMemRead, ctlMemWrite, ctlAluSrc, ctlAluOp,
        fwdA, fwdB, pcHold, pcLoad, flushId, flushEx);

    aluUnit alu(clk, rstN_i, fwdA, fwdB, exA, exB, exImm, exAluOp, exAluSrc,
        exRd, exRegWrite, exMemRead, exMemWrite, wbData,
        memAddr, memStoreData, memRd, memRegWrite, memRead, memWrite);

    memOrIo memorio(clk, rstN_i, memAddr, memStoreData, memRd, memRegWrite,
        memRead, memWrite, ioIn_i,
        wbData, wbRd, wbRegWrite, ioOut_o, ioWe_o);

endmodule

`default_nettype wire

/* verif/tbClock.sv */
`timescale 1ns/1ns
`default_nettype none

module tbClock #(
    parameter int PeriodNs = 100
) (
    output logic clk_o
);
    initial begin
        clk_o = 1'b0;
    end

    always #(PeriodNs / 2) clk_o = ~clk_o;   // Half period per toggle

endmodule

`default_nettype wire

/* verif/cpuTb.sv */
`timescale 1ns/1ns
`default_nettype none

module cpuTb import cpuPkg::*; ();
    localparam int RstCycles = 4;
    localparam int CyclesPerInstr = 200;
    localparam logic [11:0] IoOffset = 12'hF00;   // -256 from x0 hits the IO word

    // R-type funct3 and funct7 bit 5 for ADD SUB AND OR XOR SLL SRL SLT
    localparam logic [2:0] RF3 [8] = '{3'b000, 3'b000, 3'b111, 3'b110,
                                       3'b100, 3'b001, 3'b101, 3'b010};
    localparam logic RAlt [8] = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};

    logic clk;
    logic rstN, upgWen, upgDone, ioWe;
    imemAddr_t upgAddr;
    word_t upgData, ioOut;
    logic [15:0] ioIn;

    word_t prog[$];          // Program being built
    word_t expQ[$];          // Expected IO writes in order, across all programs
    int wrIdx = 0;           // Head of expQ
    int errCount = 0;
    int budget = 0;          // Watchdog limit in cycles
    int cycleCount = 0;
    logic loading = 1'b0;    // Core held for upload

    tbClock clockGen(.clk_o(clk));

    cpuTop UUT(
        .clk(clk),
        .rstN_i(rstN),
        .upgWen_i(upgWen),
        .upgAddr_i(upgAddr),
        .upgData_i(upgData),
        .upgDone_i(upgDone),
        .ioIn_i(ioIn),
        .ioOut_o(ioOut),
        .ioWe_o(ioWe)
    );

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic word_t encR(input logic alt, input logic [2:0] f3,
                                   input regAddr_t rd, rs1, rs2);
        return {alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t encAddi(input regAddr_t rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic word_t encLw(input regAddr_t rd, rs1, input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic word_t encSw(input regAddr_t rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t encBeq(input regAddr_t rs1, rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t encJal(input regAddr_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // Result of an RV32I register operation
    function automatic word_t rvResult(input logic [2:0] f3, input logic alt,
                                       input word_t a, b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: return a >> b[4:0];
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic addNops(input int n);
        repeat (n) prog.push_back(encAddi(5'd0, 5'd0, 12'd0));
    endtask

    task automatic storeToIo(input regAddr_t rs);
        prog.push_back(encSw(rs, 5'd0, IoOffset));
    endtask

    // ADDI and every R-type op, spaced out or back to back
    task automatic buildAluTests(input logic spaced);
        logic [11:0] immA, immB;
        word_t a, b;
        int op;
        prog.delete();
        for (op = 0; op < 9; op++) begin
            immA = 12'($urandom);
            immB = 12'($urandom);
            a = sext12(immA);
            b = sext12(immB);
            // Swapped order puts each operand on both forwarding paths
            if (op % 2 == 0) begin
                prog.push_back(encAddi(5'd1, 5'd0, immA));
                prog.push_back(encAddi(5'd2, 5'd0, immB));
            end else begin
                prog.push_back(encAddi(5'd2, 5'd0, immB));
                prog.push_back(encAddi(5'd1, 5'd0, immA));
            end
            if (spaced) addNops(3);
            if (op == 8) begin
                prog.push_back(encAddi(5'd3, 5'd1, immB));
                expQ.push_back(a + b);
            end else begin
                prog.push_back(encR(RAlt[op], RF3[op], 5'd3, 5'd1, 5'd2));
                expQ.push_back(rvResult(RF3[op], RAlt[op], a, b));
            end
            if (spaced) addNops(3);
            storeToIo(5'd3);
        end
        prog.push_back(encJal(5'd0, 21'd0));   // Park loop
    endtask

    task automatic buildMemBranchIo();
        logic [11:0] immV, immP, dOff;
        logic [15:0] ioVal;
        int jalPc;
        prog.delete();
        immV = 12'($urandom);
        immP = 12'($urandom);
        dOff = {2'b00, 8'($urandom), 2'b00};   // Word in the low 1 KB
        ioVal = 16'($urandom) | 16'h8000;      // Top bit set so zero extension shows
        ioIn <= ioVal;

        // Data memory round trip
        prog.push_back(encAddi(5'd5, 5'd0, immV));
        prog.push_back(encAddi(5'd6, 5'd0, dOff));
        prog.push_back(encSw(5'd5, 5'd6, 12'd0));
        prog.push_back(encLw(5'd7, 5'd6, 12'd0));
        addNops(1);
        storeToIo(5'd7);
        expQ.push_back(sext12(immV));

        // IO input read back
        prog.push_back(encLw(5'd8, 5'd0, IoOffset));
        addNops(1);
        storeToIo(5'd8);
        expQ.push_back({16'd0, ioVal});

        prog.push_back(encAddi(5'd10, 5'd0, immP));
        prog.push_back(encAddi(5'd11, 5'd0, immP));
        prog.push_back(encAddi(5'd12, 5'd0, immP ^ 12'h001));
        addNops(3);                                     // BEQ compare has no forwarding
        prog.push_back(encBeq(5'd10, 5'd11, 13'd8));    // Taken
        storeToIo(5'd12);                               // Skipped
        prog.push_back(encBeq(5'd10, 5'd12, 13'd8));    // Not taken
        storeToIo(5'd11);
        expQ.push_back(sext12(immP));
        jalPc = prog.size();
        prog.push_back(encJal(5'd13, 21'd8));
        storeToIo(5'd12);                               // Skipped
        storeToIo(5'd13);
        expQ.push_back(word_t'(jalPc * 4 + 4));         // Link is PC + 4
        prog.push_back(encJal(5'd0, 21'd0));
    endtask

    // Reset, upload prog, run until every expected write is seen
    task automatic runProgram();
        int i;
        budget += RstCycles + CyclesPerInstr * prog.size();
        @(posedge clk);
        rstN <= 1'b0;
        upgDone <= 1'b0;
        repeat (RstCycles) @(posedge clk);
        rstN <= 1'b1;
        loading <= 1'b1;
        for (i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            upgWen <= 1'b1;
            upgAddr <= imemAddr_t'(i);
            upgData <= prog[i];
        end
        @(posedge clk);
        upgWen <= 1'b0;
        @(posedge clk);
        loading <= 1'b0;
        upgDone <= 1'b1;
        while (wrIdx < expQ.size()) @(posedge clk);
        repeat (20) @(posedge clk);   // A stray write would show here
        upgDone <= 1'b0;
    endtask

    task automatic finishRun();
        int missing;
        missing = expQ.size() - wrIdx;
        if (missing > 0) begin
            $display("%0d expected IO writes never happened", missing);
            errCount += missing;
        end
        $display("Run finished with %0d errors", errCount);
        if (errCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        if (ioWe) begin
            wrIdx <= wrIdx + 1;   // Pop the head
        end
    end

    // Outputs are stable at the falling edge
    writeExpected: assert property (@(negedge clk) ioWe |-> wrIdx < expQ.size())
        else begin
            errCount++;
            $display("At %0t an IO write of %h came with no write left to expect",
                $time, ioOut);
        end

    writeValue: assert property (@(negedge clk)
        ioWe && wrIdx < expQ.size() |-> ioOut == expQ[wrIdx])
        else begin
            errCount++;
            $display("Fail at %0t: ioOut_o expected %h, actual %h", $time, expQ[wrIdx], ioOut);
        end

    quietWe: assert property (@(negedge clk) loading |-> !ioWe)
        else begin
            errCount++;
            $display("Fail at %0t: ioWe_o expected 0, actual %b", $time, ioWe);
        end

    quietOut: assert property (@(negedge clk) loading |-> ioOut == '0)
        else begin
            errCount++;
            $display("Fail at %0t: ioOut_o expected 00000000, actual %h", $time, ioOut);
        end

    initial begin : watchdog
        @(posedge clk);
        while (cycleCount <= budget) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout after %0d cycles, the program never finished its expected IO writes",
            cycleCount);
        errCount++;
        finishRun();
    end

    initial begin
        rstN = 1'b0;
        upgWen = 1'b0;
        upgAddr = '0;
        upgData = '0;
        upgDone = 1'b0;
        ioIn = '0;
        void'($urandom(32'h636b_e052));
        buildAluTests(1'b1);
        runProgram();
        buildAluTests(1'b0);
        runProgram();
        buildMemBranchIo();
        runProgram();
        finishRun();
    end

endmodule

`default_nettype wire

/* cpuTop.f */
+incdir+common
common/cpuPkg.sv
src/fetch/instrFetch.sv
src/decode/instrDecode.sv
src/decode/pipeControl.sv
src/execute/aluUnit.sv
src/memory/memOrIo.sv
src/cpuTop.sv
verif/tbClock.sv
verif/cpuTb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile the cpuTop testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        -f cpuTop.f --top-module cpuTb; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/VcpuTb)"
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
